//--- verilog/aes_pkg.sv
// ------------------------------
// AES-128 constants, shared types and the GF(2^8) arithmetic,
// referenced by scoped name from the expander, store and engine
// ------------------------------
`default_nettype none

package aes_pkg;

    typedef logic [127:0] block_t;
    typedef logic [7:0]   byte_t;
    typedef logic [3:0]   round_t;

    localparam round_t     NUM_ROUNDS     = 4'd10;
    localparam logic [3:0] NUM_ROUND_KEYS = 4'd11;
    localparam byte_t      RCON_FIRST     = 8'h01;

    // ------------------------------
    // field arithmetic
    // ------------------------------

    // multiply by x, reduce by x^8 + x^4 + x^3 + x + 1
    function automatic byte_t gf_xtime(byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t p;
        byte_t x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p = p ^ x;
            end
            x = gf_xtime(x);
        end
        return p;
    endfunction

    // a^254 == a^-1; zero falls out as zero
    function automatic byte_t gf_inv(byte_t a);
        byte_t r;
        r = a;
        // square and multiply up to a^127
        for (int i = 0; i < 6; i++) begin
            r = gf_mul(gf_mul(r, r), a);
        end
        return gf_mul(r, r);
    endfunction

    function automatic byte_t rotl8(byte_t x, int n);
        return (x << n) | (x >> (8 - n));
    endfunction

    // ------------------------------
    // s-boxes from inverse plus affine map
    // ------------------------------

    function automatic byte_t sbox(byte_t x);
        byte_t b;
        b = gf_inv(x);
        return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
    endfunction

    // undo the affine map first, then invert
    function automatic byte_t inv_sbox(byte_t x);
        return gf_inv(rotl8(x, 1) ^ rotl8(x, 3) ^ rotl8(x, 6) ^ 8'h05);
    endfunction

    // ------------------------------
    // block transforms, FIPS byte n at bits 127-8n
    // ------------------------------

    function automatic block_t inv_shift_rows(block_t s);
        block_t res;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                res[127 - 8 * (4 * ((c + r) % 4) + r) -: 8] = s[127 - 8 * (4 * c + r) -: 8];
            end
        end
        return res;
    endfunction

    function automatic block_t inv_sub_bytes(block_t s);
        block_t res;
        for (int i = 0; i < 16; i++) begin
            res[8 * i +: 8] = inv_sbox(s[8 * i +: 8]);
        end
        return res;
    endfunction

    function automatic block_t inv_mix_columns(block_t s);
        block_t res;
        byte_t  a  [4];
        byte_t  x2 [4];
        byte_t  x4 [4];
        byte_t  x8 [4];
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                a[r]  = s[127 - 8 * (4 * c + r) -: 8];
                x2[r] = gf_xtime(a[r]);
                x4[r] = gf_xtime(x2[r]);
                x8[r] = gf_xtime(x4[r]);
            end
            // row r: 0e 0b 0d 09 rotated right by r
            for (int r = 0; r < 4; r++) begin
                res[127 - 8 * (4 * c + r) -: 8] =
                    (x8[r] ^ x4[r] ^ x2[r]) ^
                    (x8[(r + 1) % 4] ^ x2[(r + 1) % 4] ^ a[(r + 1) % 4]) ^
                    (x8[(r + 2) % 4] ^ x4[(r + 2) % 4] ^ a[(r + 2) % 4]) ^
                    (x8[(r + 3) % 4] ^ a[(r + 3) % 4]);
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- verilog/aes_round_key_store.sv
// ------------------------------
// eleven round-key registers, written by the expander and read
// combinationally by the round engine
// ------------------------------
`default_nettype none

module aes_round_key_store (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wr_en,
    input  aes_pkg::round_t wr_round,
    input  aes_pkg::block_t wr_key,
    input  aes_pkg::round_t rd_round,
    output aes_pkg::block_t rd_key,
    output logic            loaded
);

    aes_pkg::block_t keys [aes_pkg::NUM_ROUND_KEYS];
    logic            loaded_q;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            keys[wr_round] <= wr_key;
        end
    end

    assign rd_key = keys[rd_round];

    // cleared by round 0, set by round 10
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loaded_q <= 1'b0;
        end else if (wr_en && wr_round == '0) begin
            loaded_q <= 1'b0;
        end else if (wr_en && wr_round == aes_pkg::NUM_ROUNDS) begin
            loaded_q <= 1'b1;
        end
    end

    // a schedule being rewritten is never offered, not even the first cycle
    assign loaded = loaded_q && !wr_en;

    assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> wr_round <= aes_pkg::NUM_ROUNDS);

endmodule

`default_nettype wire

//--- verilog/aes_key_expander.sv
// ------------------------------
// AES-128 key schedule, one round key per clock into the store
// ------------------------------
`default_nettype none

module aes_key_expander (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            key_valid,
    input  aes_pkg::block_t key,
    output logic            key_ready,
    input  logic            busy,
    output logic            wr_en,
    output aes_pkg::round_t wr_round,
    output aes_pkg::block_t wr_key
);

    logic            active;
    logic            key_take;
    aes_pkg::round_t cnt;
    aes_pkg::byte_t  rcon;
    aes_pkg::block_t rk;
    aes_pkg::block_t rk_next;
    logic [31:0]     temp;

    // no new key while a block is in the engine
    assign key_ready = !active && !busy;
    assign key_take  = key_valid && key_ready;

    // current key goes out as round cnt
    assign wr_en    = active;
    assign wr_round = cnt;
    assign wr_key   = rk;

    // ------------------------------
    // next round key
    // ------------------------------
    always_comb begin
        // SubWord(RotWord(w3)) ^ rcon
        temp = {aes_pkg::sbox(rk[23:16]), aes_pkg::sbox(rk[15:8]),
                aes_pkg::sbox(rk[7:0]), aes_pkg::sbox(rk[31:24])} ^ {rcon, 24'h000000};
        rk_next[127:96] = rk[127:96] ^ temp;
        rk_next[95:64]  = rk[95:64] ^ rk_next[127:96];
        rk_next[63:32]  = rk[63:32] ^ rk_next[95:64];
        rk_next[31:0]   = rk[31:0] ^ rk_next[63:32];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            cnt    <= '0;
            rcon   <= aes_pkg::RCON_FIRST;
        end else if (key_take) begin
            active <= 1'b1;
            cnt    <= '0;
            rcon   <= aes_pkg::RCON_FIRST;
        end else if (active) begin
            if (cnt == aes_pkg::NUM_ROUNDS) begin
                active <= 1'b0;
            end else begin
                cnt  <= cnt + 1'b1;
                rcon <= aes_pkg::gf_xtime(rcon);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (key_take) begin
            rk <= key;
        end else if (active && cnt != aes_pkg::NUM_ROUNDS) begin
            rk <= rk_next;
        end
    end

    // engine stays idle while the schedule is written
    assert property (@(posedge clk) disable iff (!rst_n) active |-> !busy);

endmodule

`default_nettype wire

//--- verilog/aes_inv_round_engine.sv
// ------------------------------
// inverse cipher FSM, one block at a time, eleven cycles per block,
// result held in the state register until the output handshake
// ------------------------------
`default_nettype none

module aes_inv_round_engine (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            blk_valid,
    input  aes_pkg::block_t blk_in,
    output logic            blk_ready,
    input  logic            loaded,
    output logic            busy,
    output aes_pkg::round_t rd_round,
    input  aes_pkg::block_t rd_key,
    output logic            out_valid,
    output aes_pkg::block_t out_block,
    input  logic            out_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_INIT,
        ST_MAIN,
        ST_DONE
    } state_t;

    state_t          state_q;
    aes_pkg::round_t round_q;
    aes_pkg::block_t st_q;
    logic            blk_take;
    aes_pkg::block_t ark;
    aes_pkg::block_t pre;
    aes_pkg::block_t rnd;

    assign blk_ready = (state_q == ST_IDLE) && loaded;
    assign blk_take  = blk_valid && blk_ready;
    // includes the accepting cycle so no key slips in beside the block
    assign busy      = (state_q != ST_IDLE) || blk_take;

    assign rd_round  = round_q;
    assign out_valid = (state_q == ST_DONE);
    assign out_block = st_q;

    // ------------------------------
    // round datapath
    // ------------------------------
    always_comb begin
        ark = st_q ^ rd_key;
        // initial step skips InvMixColumns
        pre = (state_q == ST_INIT) ? ark : aes_pkg::inv_mix_columns(ark);
        rnd = aes_pkg::inv_sub_bytes(aes_pkg::inv_shift_rows(pre));
    end

    always_ff @(posedge clk) begin
        case (state_q)
            ST_IDLE: begin
                if (blk_take) begin
                    st_q <= blk_in;
                end
            end
            ST_INIT: st_q <= rnd;
            // round key 0 is the final AddRoundKey only
            ST_MAIN: st_q <= (round_q == '0) ? ark : rnd;
            default: st_q <= st_q;
        endcase
    end

    // ------------------------------
    // control
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            round_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (blk_take) begin
                        state_q <= ST_INIT;
                        round_q <= aes_pkg::NUM_ROUNDS;
                    end
                end
                ST_INIT: begin
                    state_q <= ST_MAIN;
                    round_q <= round_q - 1'b1;
                end
                ST_MAIN: begin
                    if (round_q == '0) begin
                        state_q <= ST_DONE;
                    end else begin
                        round_q <= round_q - 1'b1;
                    end
                end
                default: begin
                    if (out_ready) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // result held steady under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_block));

endmodule

`default_nettype wire

//--- verilog/aes_decipher_top.sv
// ------------------------------
// AES-128 decipher core: key expander, round key store and engine
// ------------------------------
`default_nettype none

module aes_decipher_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            key_valid,
    input  aes_pkg::block_t key,
    output logic            key_ready,
    input  logic            blk_valid,
    input  aes_pkg::block_t blk_in,
    output logic            blk_ready,
    output logic            out_valid,
    output aes_pkg::block_t out_block,
    input  logic            out_ready
);

    logic            wr_en;
    aes_pkg::round_t wr_round;
    aes_pkg::block_t wr_key;
    aes_pkg::round_t rd_round;
    aes_pkg::block_t rd_key;
    logic            loaded;
    logic            busy;

    aes_key_expander u_expander (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_valid (key_valid),
        .key       (key),
        .key_ready (key_ready),
        .busy      (busy),
        .wr_en     (wr_en),
        .wr_round  (wr_round),
        .wr_key    (wr_key)
    );

    aes_round_key_store u_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_round (wr_round),
        .wr_key   (wr_key),
        .rd_round (rd_round),
        .rd_key   (rd_key),
        .loaded   (loaded)
    );

    aes_inv_round_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .blk_valid (blk_valid),
        .blk_in    (blk_in),
        .blk_ready (blk_ready),
        .loaded    (loaded),
        .busy      (busy),
        .rd_round  (rd_round),
        .rd_key    (rd_key),
        .out_valid (out_valid),
        .out_block (out_block),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

//--- testbench/tb_aes_decipher.sv
// ------------------------------
// directed testbench for the AES-128 decipher core,
// FIPS-197 known-answer vectors plus handshake and back-pressure checks
// ------------------------------
`default_nettype none

module tb_aes_decipher;

    localparam int TIMEOUT    = 200;
    localparam int LATENCY    = 11;
    localparam int KEY_CYCLES = 11;

    // FIPS-197 appendix C.1 and appendix B
    localparam aes_pkg::block_t KEY_C1 = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_pkg::block_t CT_C1  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam aes_pkg::block_t PT_C1  = 128'h00112233445566778899aabbccddeeff;
    localparam aes_pkg::block_t KEY_B  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam aes_pkg::block_t CT_B   = 128'h3925841d02dc09fbdc118597196a0b32;
    localparam aes_pkg::block_t PT_B   = 128'h3243f6a8885a308d313198a2e0370734;

    logic            clk;
    logic            rst_n;
    logic            key_valid;
    aes_pkg::block_t key;
    logic            key_ready;
    logic            blk_valid;
    aes_pkg::block_t blk_in;
    logic            blk_ready;
    logic            out_valid;
    aes_pkg::block_t out_block;
    logic            out_ready;

    aes_decipher_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_valid (key_valid),
        .key       (key),
        .key_ready (key_ready),
        .blk_valid (blk_valid),
        .blk_in    (blk_in),
        .blk_ready (blk_ready),
        .out_valid (out_valid),
        .out_block (out_block),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic report_failure(string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_block(string name, aes_pkg::block_t got, aes_pkg::block_t exp);
        if (got !== exp) begin
            report_failure($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            report_failure($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    // ------------------------------
    // drive tasks
    // ------------------------------
    // ready sampled mid-cycle, transfer on the following edge
    task automatic load_key(aes_pkg::block_t k);
        int n;
        @(posedge clk);
        key_valid <= 1'b1;
        key       <= k;
        n = 0;
        @(negedge clk);
        while (key_ready !== 1'b1) begin
            n++;
            if (n > TIMEOUT) begin
                report_failure("timeout waiting for key_ready before the key transfer");
            end
            @(negedge clk);
        end
        @(posedge clk);
        key_valid <= 1'b0;
        // schedule runs, no block may enter meanwhile
        n = 0;
        @(negedge clk);
        while (key_ready !== 1'b1) begin
            check_bit("blk_ready", blk_ready, 1'b0);
            n++;
            if (n > TIMEOUT) begin
                report_failure("timeout waiting for the key schedule to finish");
            end
            @(negedge clk);
        end
        check_count("key schedule cycles", n, KEY_CYCLES);
        check_bit("blk_ready", blk_ready, 1'b1);
    endtask

    task automatic send_block(aes_pkg::block_t ct);
        int n;
        @(posedge clk);
        blk_valid <= 1'b1;
        blk_in    <= ct;
        n = 0;
        @(negedge clk);
        while (blk_ready !== 1'b1) begin
            n++;
            if (n > TIMEOUT) begin
                report_failure("timeout waiting for blk_ready");
            end
            @(negedge clk);
        end
        @(posedge clk);
        blk_valid <= 1'b0;
    endtask

    // called right after send_block, so the count starts at acceptance
    task automatic take_result(aes_pkg::block_t exp, int stall);
        int n;
        int i;
        n = 0;
        @(negedge clk);
        while (out_valid !== 1'b1) begin
            check_bit("blk_ready", blk_ready, 1'b0);
            check_bit("key_ready", key_ready, 1'b0);
            n++;
            if (n > TIMEOUT) begin
                report_failure("timeout waiting for out_valid");
            end
            @(negedge clk);
        end
        check_count("block latency", n, LATENCY);
        check_block("out_block", out_block, exp);
        // out_ready still low here
        for (i = 0; i < stall; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_bit("out_valid", out_valid, 1'b1);
            check_bit("blk_ready", blk_ready, 1'b0);
            check_block("out_block", out_block, exp);
        end
        @(posedge clk);
        out_ready <= 1'b1;
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b1);
        check_block("out_block", out_block, exp);
        @(posedge clk);
        out_ready <= 1'b0;
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("blk_ready", blk_ready, 1'b1);
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic after_reset_state();
        int n;
        n = 0;
        @(negedge clk);
        check_bit("blk_ready", blk_ready, 1'b0);
        check_bit("out_valid", out_valid, 1'b0);
        while (key_ready !== 1'b1) begin
            n++;
            if (n > TIMEOUT) begin
                report_failure("timeout waiting for key_ready after reset");
            end
            @(negedge clk);
        end
    endtask

    task automatic appendix_c1_vector();
        load_key(KEY_C1);
        send_block(CT_C1);
        take_result(PT_C1, 0);
    endtask

    task automatic key_reload();
        load_key(KEY_B);
        send_block(CT_B);
        take_result(PT_B, 0);
    endtask

    task automatic back_pressure();
        int stall;
        stall = int'($urandom_range(20, 1));
        send_block(CT_B);
        take_result(PT_B, stall);
    endtask

    task automatic back_to_back();
        load_key(KEY_C1);
        send_block(CT_C1);
        take_result(PT_C1, 0);
        load_key(KEY_B);
        send_block(CT_B);
        take_result(PT_B, 0);
        load_key(KEY_C1);
        send_block(CT_C1);
        take_result(PT_C1, 0);
        // same block again under the same schedule
        send_block(CT_C1);
        take_result(PT_C1, 0);
    endtask

    initial begin
        rst_n     = 1'b0;
        key_valid = 1'b0;
        key       = '0;
        blk_valid = 1'b0;
        blk_in    = '0;
        out_ready = 1'b0;
        void'($urandom(20));
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        after_reset_state();
        appendix_c1_vector();
        key_reload();
        back_pressure();
        back_to_back();
        @(posedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
verilog/aes_pkg.sv
verilog/aes_round_key_store.sv
verilog/aes_key_expander.sv
verilog/aes_inv_round_engine.sv
verilog/aes_decipher_top.sv
testbench/tb_aes_decipher.sv

//--- run_sim.sh
#!/bin/sh
# compile the AES decipher testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_aes_decipher

out=$(./obj_dir/Vtb_aes_decipher 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Everything OK"; then
    exit 0
fi
exit 1
